/* design/bus_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_decoder (
	input  wire logic                       sys_rst_i,
	input  wire logic                       bus_cyc_i,
	input  wire logic                       bus_stb_i,
	input  wire logic [sys_pkg::ADDR_W-1:0] bus_adr_i,
	input  wire logic                       slv_ack_i,
	input  wire logic [sys_pkg::DATA_W-1:0] slv_dat_i,
	output logic                            slv_stb_o,
	output logic                            bus_ack_o,
	output logic                            bus_err_o,
	output logic [sys_pkg::DATA_W-1:0]      bus_dat_o
);
	import sys_pkg::*;

	logic ctrl_hit;
	logic ctrl_sel;

	// ############################################################
	// Window match
	// ############################################################
	assign ctrl_hit =
		(bus_adr_i[ADDR_W-1:CTRL_MATCH_LSB] == CTRL_BASE[ADDR_W-1:CTRL_MATCH_LSB]);

	assign ctrl_sel = bus_cyc_i & ctrl_hit;

	assign slv_stb_o = ctrl_sel & bus_stb_i;

	// ############################################################
	// Response steering
	// ############################################################
	assign bus_ack_o = ctrl_sel & slv_ack_i;
	assign bus_dat_o = ctrl_sel ? slv_dat_i : '0; // Zero when idle.

	// Unmapped cycle answers in the strobe cycle.
	assign bus_err_o = bus_cyc_i & bus_stb_i & ~ctrl_hit & ~sys_rst_i;

endmodule

`default_nettype wire

/* design/ctrl_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module ctrl_regs (
	input  wire logic                          clk_i,
	input  wire logic                          reset_n,
	input  wire logic                          sys_rst_i,
	input  wire logic                          slv_stb_i,
	input  wire logic                          bus_we_i,
	input  wire logic [sys_pkg::REG_SEL_W-1:0] reg_sel_i,
	input  wire logic [sys_pkg::DATA_W-1:0]    bus_dat_i,
	input  wire logic                          t0_tick_i,
	input  wire logic                          t1_tick_i,
	output logic                               slv_ack_o,
	output logic [sys_pkg::DATA_W-1:0]         slv_dat_o,
	output logic [sys_pkg::GPIO_W-1:0]         gpio_o,
	output logic [sys_pkg::TIMER_W-1:0]        t0_load_o,
	output logic [sys_pkg::TIMER_W-1:0]        t1_load_o,
	output logic                               t0_en_o,
	output logic                               t1_en_o,
	output logic                               wdt_en_o,
	output logic                               wdt_kick_o,
	input  wire logic                          irq_block_i,
	output logic [sys_pkg::IRQ_W-1:0]          irq_n_o
);
	import sys_pkg::*;

	logic              wr_en;
	logic [CTRL_W-1:0] ctrl_q;
	logic [1:0]        irq_pend;
	logic [1:0]        pend_clr;

	// Writes only in the first strobe cycle.
	assign wr_en = slv_stb_i & bus_we_i & ~slv_ack_o;

	assign pend_clr = (wr_en && reg_sel_i == REG_IRQ_PEND) ? bus_dat_i[1:0] : 2'b00;

	// ############################################################
	// Register file
	// ############################################################
	always_ff @(posedge clk_i or negedge reset_n) begin
		if (!reset_n) begin
			slv_ack_o <= 1'b0;
			wdt_kick_o <= 1'b0;
			gpio_o <= GPIO_RESET;
			t0_load_o <= TIMER_LOAD_RESET;
			t1_load_o <= TIMER_LOAD_RESET;
			ctrl_q <= CTRL_RESET;
			irq_pend <= 2'b00;
		end else if (sys_rst_i) begin
			slv_ack_o <= 1'b0;
			wdt_kick_o <= 1'b0;
			gpio_o <= GPIO_RESET;
			t0_load_o <= TIMER_LOAD_RESET;
			t1_load_o <= TIMER_LOAD_RESET;
			ctrl_q <= CTRL_RESET;
			irq_pend <= 2'b00;
		end else begin
			slv_ack_o <= slv_stb_i & ~slv_ack_o;
			wdt_kick_o <= wr_en && (reg_sel_i == REG_WDT_KICK);
			if (wr_en) begin
				case (reg_sel_i)
					REG_GPIO:    gpio_o <= bus_dat_i[GPIO_W-1:0];
					REG_T0_LOAD: t0_load_o <= bus_dat_i[TIMER_W-1:0];
					REG_T1_LOAD: t1_load_o <= bus_dat_i[TIMER_W-1:0];
					REG_CTRL:    ctrl_q <= bus_dat_i[CTRL_W-1:0];
					default:     ;
				endcase
			end
			// Tick beats a clear in the same cycle.
			irq_pend <= (irq_pend & ~pend_clr) | {t1_tick_i, t0_tick_i};
		end
	end

	assign t0_en_o = ctrl_q[CTRL_T0_EN];
	assign t1_en_o = ctrl_q[CTRL_T1_EN];
	assign wdt_en_o = ctrl_q[CTRL_WDT_EN];

	// ############################################################
	// Read mux and interrupt vector
	// ############################################################
	always_comb begin
		slv_dat_o = '0;
		case (reg_sel_i)
			REG_GPIO:     slv_dat_o[GPIO_W-1:0] = gpio_o;
			REG_T0_LOAD:  slv_dat_o[TIMER_W-1:0] = t0_load_o;
			REG_T1_LOAD:  slv_dat_o[TIMER_W-1:0] = t1_load_o;
			REG_CTRL:     slv_dat_o[CTRL_W-1:0] = ctrl_q;
			REG_IRQ_PEND: slv_dat_o[1:0] = irq_pend;
			REG_ID:       slv_dat_o = CTRL_ID;
			default:      ; // Kick and holes read zero.
		endcase
	end

	always_comb begin
		irq_n_o = '1;
		irq_n_o[IRQ_T0_BIT] = ~(irq_pend[0] & ~irq_block_i);
		irq_n_o[IRQ_T1_BIT] = ~(irq_pend[1] & ~irq_block_i);
	end

endmodule

`default_nettype wire

/* design/reset_seq.sv */
`timescale 1ns/1ns
`default_nettype none

module reset_seq (
	input  wire logic clk_i,
	input  wire logic reset_n,
	input  wire logic wdt_bite_i,
	output logic      sys_rst_o
);
	import sys_pkg::*;

	logic [RST_STRETCH_W-1:0] stretch_cnt;

	always_ff @(posedge clk_i or negedge reset_n) begin
		if (!reset_n) begin
			stretch_cnt <= '0;
		end else if (wdt_bite_i) begin
			stretch_cnt <= '0; // Same length as power-up.
		end else if (!stretch_cnt[RST_STRETCH_W-1]) begin
			stretch_cnt <= stretch_cnt + 1'b1;
		end
	end

	assign sys_rst_o = ~stretch_cnt[RST_STRETCH_W-1];

endmodule

`default_nettype wire

/* design/sys_pkg.sv */
`default_nettype none

package sys_pkg;

	// ############################################################
	// Bus and address map
	// ############################################################
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	localparam logic [ADDR_W-1:0] CTRL_BASE = 32'h8000_0180; // 64-byte control window.
	localparam int CTRL_MATCH_LSB = 6;
	localparam int REG_SEL_W = 4; // Word offset from address bits 5:2.

	localparam logic [REG_SEL_W-1:0] REG_GPIO     = 4'd0;
	localparam logic [REG_SEL_W-1:0] REG_T0_LOAD  = 4'd1;
	localparam logic [REG_SEL_W-1:0] REG_T1_LOAD  = 4'd2;
	localparam logic [REG_SEL_W-1:0] REG_CTRL     = 4'd3;
	localparam logic [REG_SEL_W-1:0] REG_IRQ_PEND = 4'd4;
	localparam logic [REG_SEL_W-1:0] REG_WDT_KICK = 4'd5;
	localparam logic [REG_SEL_W-1:0] REG_ID       = 4'd6;

	localparam logic [DATA_W-1:0] CTRL_ID = 32'h5359_5343;

	// ############################################################
	// Widths and reset values
	// ############################################################
	localparam int GPIO_W = 12;
	localparam int TIMER_W = 16;
	localparam int NUM_TIMERS = 2;
	localparam int WDT_W = 16;
	localparam int RST_STRETCH_W = 3; // Top bit sets after 4 cycles.

	localparam logic [WDT_W-1:0] WDT_TIMEOUT = 16'd200; // Short for simulation.

	// Enable bits in REG_CTRL.
	localparam int CTRL_W = 3;
	localparam int CTRL_T0_EN = 0;
	localparam int CTRL_T1_EN = 1;
	localparam int CTRL_WDT_EN = 2;

	localparam logic [GPIO_W-1:0] GPIO_RESET = '0;
	localparam logic [TIMER_W-1:0] TIMER_LOAD_RESET = 16'hffff;
	localparam logic [CTRL_W-1:0] CTRL_RESET = '0; // All counters stopped.

	localparam int IRQ_W = 32;
	localparam int IRQ_T0_BIT = 5;
	localparam int IRQ_T1_BIT = 6;

endpackage

`default_nettype wire

/* design/sys_top.sv */
`timescale 1ns/1ns
`default_nettype none

module sys_top (
	input  wire logic                       clk_i,
	input  wire logic                       reset_n,
	input  wire logic                       bus_cyc_i,
	input  wire logic                       bus_stb_i,
	input  wire logic                       bus_we_i,
	input  wire logic [sys_pkg::ADDR_W-1:0] bus_adr_i,
	input  wire logic [sys_pkg::DATA_W-1:0] bus_dat_i,
	output logic [sys_pkg::DATA_W-1:0]      bus_dat_o,
	output logic                            bus_ack_o,
	output logic                            bus_err_o,
	input  wire logic                       irq_block_i,
	output logic [sys_pkg::GPIO_W-1:0]      gpio_o,
	output logic [sys_pkg::IRQ_W-1:0]       irq_n_o,
	output logic                            watchdog_o
);
	import sys_pkg::*;

	logic               sys_rst;
	logic               slv_stb;
	logic               slv_ack;
	logic [DATA_W-1:0]  slv_dat;
	logic [REG_SEL_W-1:0] reg_sel;
	logic [TIMER_W-1:0] t0_load;
	logic [TIMER_W-1:0] t1_load;
	logic               t0_en;
	logic               t1_en;
	logic               wdt_en;
	logic               wdt_kick;
	logic               t0_tick;
	logic               t1_tick;
	logic               wdt_bite;

	assign reg_sel = bus_adr_i[REG_SEL_W+1:2]; // Word offset in window.
	assign watchdog_o = wdt_bite;

	reset_seq reset_seq_i (
		.clk_i      (clk_i),
		.reset_n    (reset_n),
		.wdt_bite_i (wdt_bite),
		.sys_rst_o  (sys_rst)
	);

	bus_decoder bus_decoder_i (
		.sys_rst_i (sys_rst),
		.bus_cyc_i (bus_cyc_i),
		.bus_stb_i (bus_stb_i),
		.bus_adr_i (bus_adr_i),
		.slv_ack_i (slv_ack),
		.slv_dat_i (slv_dat),
		.slv_stb_o (slv_stb),
		.bus_ack_o (bus_ack_o),
		.bus_err_o (bus_err_o),
		.bus_dat_o (bus_dat_o)
	);

	ctrl_regs ctrl_regs_i (
		.clk_i       (clk_i),
		.reset_n     (reset_n),
		.sys_rst_i   (sys_rst),
		.slv_stb_i   (slv_stb),
		.bus_we_i    (bus_we_i),
		.reg_sel_i   (reg_sel),
		.bus_dat_i   (bus_dat_i),
		.t0_tick_i   (t0_tick),
		.t1_tick_i   (t1_tick),
		.slv_ack_o   (slv_ack),
		.slv_dat_o   (slv_dat),
		.gpio_o      (gpio_o),
		.t0_load_o   (t0_load),
		.t1_load_o   (t1_load),
		.t0_en_o     (t0_en),
		.t1_en_o     (t1_en),
		.wdt_en_o    (wdt_en),
		.wdt_kick_o  (wdt_kick),
		.irq_block_i (irq_block_i),
		.irq_n_o     (irq_n_o)
	);

	timer_unit timer_unit_i (
		.clk_i      (clk_i),
		.reset_n    (reset_n),
		.sys_rst_i  (sys_rst),
		.t0_load_i  (t0_load),
		.t1_load_i  (t1_load),
		.t0_en_i    (t0_en),
		.t1_en_i    (t1_en),
		.wdt_en_i   (wdt_en),
		.wdt_kick_i (wdt_kick),
		.t0_tick_o  (t0_tick),
		.t1_tick_o  (t1_tick),
		.wdt_bite_o (wdt_bite)
	);

endmodule

`default_nettype wire

/* design/timer_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module timer_unit (
	input  wire logic                        clk_i,
	input  wire logic                        reset_n,
	input  wire logic                        sys_rst_i,
	input  wire logic [sys_pkg::TIMER_W-1:0] t0_load_i,
	input  wire logic [sys_pkg::TIMER_W-1:0] t1_load_i,
	input  wire logic                        t0_en_i,
	input  wire logic                        t1_en_i,
	input  wire logic                        wdt_en_i,
	input  wire logic                        wdt_kick_i,
	output logic                             t0_tick_o,
	output logic                             t1_tick_o,
	output logic                             wdt_bite_o
);
	import sys_pkg::*;

	logic [TIMER_W-1:0]    tmr_load [NUM_TIMERS];
	logic [TIMER_W-1:0]    tmr_cnt [NUM_TIMERS];
	logic [NUM_TIMERS-1:0] tmr_en;
	logic [NUM_TIMERS-1:0] tmr_tick;
	logic [WDT_W-1:0]      wdt_cnt;

	assign tmr_load[0] = t0_load_i;
	assign tmr_load[1] = t1_load_i;
	assign tmr_en = {t1_en_i, t0_en_i};

	// ############################################################
	// Reload timers
	// ############################################################
	always_ff @(posedge clk_i or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < NUM_TIMERS; i++) begin
				tmr_cnt[i] <= '0;
			end
			tmr_tick <= '0;
		end else begin
			for (int i = 0; i < NUM_TIMERS; i++) begin
				if (sys_rst_i || !tmr_en[i]) begin
					tmr_cnt[i] <= tmr_load[i]; // Parked at load.
					tmr_tick[i] <= 1'b0;
				end else if (tmr_cnt[i] == '0) begin
					tmr_cnt[i] <= tmr_load[i];
					tmr_tick[i] <= 1'b1;
				end else begin
					tmr_cnt[i] <= tmr_cnt[i] - 1'b1;
					tmr_tick[i] <= 1'b0;
				end
			end
		end
	end

	assign t0_tick_o = tmr_tick[0];
	assign t1_tick_o = tmr_tick[1];

	// ############################################################
	// Watchdog
	// ############################################################
	always_ff @(posedge clk_i or negedge reset_n) begin
		if (!reset_n) begin
			wdt_cnt <= WDT_TIMEOUT;
			wdt_bite_o <= 1'b0;
		end else if (sys_rst_i || !wdt_en_i || wdt_kick_i) begin
			wdt_cnt <= WDT_TIMEOUT;
			wdt_bite_o <= 1'b0;
		end else begin
			// Holds at zero so the bite fires once.
			if (wdt_cnt != '0) begin
				wdt_cnt <= wdt_cnt - 1'b1;
			end
			wdt_bite_o <= (wdt_cnt == WDT_W'(1));
		end
	end

endmodule

`default_nettype wire

/* mm_sysctl.f */
design/sys_pkg.sv
design/reset_seq.sv
design/bus_decoder.sv
design/ctrl_regs.sv
design/timer_unit.sv
design/sys_top.sv
verif/tb_clock.sv
verif/sys_top_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module sys_top_tb -f mm_sysctl.f -o sys_top_sim &&
./obj_dir/sys_top_sim | tee /dev/stderr | grep -qx "TEST PASSED" &&
echo "Simulation run: pass" ||
{ echo "Simulation run: fail"; exit 1; }

/* verif/sys_stimulus.txt */
# op address data expected (hex). WAIT, K and D take a cycle count in the data column.
# G writes a random GPIO pattern, B drives irq_block_i, V checks the interrupt vector.
R 80000180 00000000 00000000
R 80000188 00000000 0000ffff
R 80000198 00000000 53595343
G 80000180 00000000 00000000
G 80000180 00000000 00000000
W 80000184 1234abcd 00000000
R 80000184 00000000 0000abcd
W 80000188 deadbeef 00000000
R 80000188 00000000 0000beef
W 8000018c fffffff8 00000000
R 8000018c 00000000 00000000
R 8000019c 00000000 00000000
E 80000140 00000000 00000000
E 800001c0 00000000 00000000
E 00000000 00000000 00000000
W 80000184 00000004 00000000
W 8000018c 00000001 00000000
WAIT 00000000 0000000a 00000000
R 80000190 00000000 00000001
V 00000000 00000000 ffffffdf
W 8000018c 00000000 00000000
W 80000190 00000001 00000000
R 80000190 00000000 00000000
V 00000000 00000000 ffffffff
W 80000188 00000003 00000000
W 8000018c 00000002 00000000
WAIT 00000000 0000000a 00000000
R 80000190 00000000 00000002
V 00000000 00000000 ffffffbf
B 00000000 00000001 00000000
V 00000000 00000000 ffffffff
B 00000000 00000000 00000000
V 00000000 00000000 ffffffbf
W 8000018c 00000000 00000000
W 80000190 00000002 00000000
R 80000190 00000000 00000000
W 8000018c 00000004 00000000
K 00000000 000001f4 00000000
D 00000000 00000118 00000000
WAIT 00000000 0000000a 00000000
R 80000180 00000000 00000000
R 80000184 00000000 0000ffff
R 80000188 00000000 0000ffff
R 8000018c 00000000 00000000
R 80000190 00000000 00000000

/* verif/sys_top_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module sys_top_tb;
	import sys_pkg::*;

	localparam int OP_W = 0;
	localparam int OP_R = 1;
	localparam int OP_E = 2;
	localparam int OP_WAIT = 3;
	localparam int OP_G = 4;
	localparam int OP_B = 5;
	localparam int OP_V = 6;
	localparam int OP_K = 7;
	localparam int OP_D = 8;
	localparam int OP_BAD = 9;
	localparam int BUS_TIMEOUT = 20;
	localparam int KICK_PERIOD = 100;
	localparam logic [ADDR_W-1:0] KICK_ADR = 32'h8000_0194;

	logic              clk;
	logic              reset_n;
	logic              bus_cyc = 1'b0;
	logic              bus_stb = 1'b0;
	logic              bus_we = 1'b0;
	logic [ADDR_W-1:0] bus_adr = '0;
	logic [DATA_W-1:0] bus_dat = '0;
	logic              irq_block = 1'b0;
	logic [DATA_W-1:0] bus_rdat;
	logic              bus_ack;
	logic              bus_err;
	logic [GPIO_W-1:0] gpio;
	logic [IRQ_W-1:0]  irq_n;
	logic              watchdog;

	int                op_q[$];
	logic [31:0]       adr_q[$];
	logic [31:0]       dat_q[$];
	logic [31:0]       exp_q[$];
	int                errors = 0;
	bit                loaded = 1'b0;
	integer            seed = 32'hdcb3;

	tb_clock tb_clock_i (
		.clk_o     (clk),
		.reset_n_o (reset_n)
	);

	sys_top sys_top_i (
		.clk_i       (clk),
		.reset_n     (reset_n),
		.bus_cyc_i   (bus_cyc),
		.bus_stb_i   (bus_stb),
		.bus_we_i    (bus_we),
		.bus_adr_i   (bus_adr),
		.bus_dat_i   (bus_dat),
		.bus_dat_o   (bus_rdat),
		.bus_ack_o   (bus_ack),
		.bus_err_o   (bus_err),
		.irq_block_i (irq_block),
		.gpio_o      (gpio),
		.irq_n_o     (irq_n),
		.watchdog_o  (watchdog)
	);

	// ############################################################
	// Stimulus file
	// ############################################################
	function automatic int op_code(input logic [63:0] tok);
		case (tok)
			64'("W"):    return OP_W;
			64'("R"):    return OP_R;
			64'("E"):    return OP_E;
			64'("WAIT"): return OP_WAIT;
			64'("G"):    return OP_G;
			64'("B"):    return OP_B;
			64'("V"):    return OP_V;
			64'("K"):    return OP_K;
			64'("D"):    return OP_D;
			default:     return OP_BAD;
		endcase
	endfunction

	function automatic string op_name(input int code);
		string names[10] = '{"write", "read", "unmapped", "wait", "gpio", "block",
			"vector", "kick", "bite", "unknown"};
		return names[code];
	endfunction

	task automatic read_stimulus();
		integer            fd;
		integer            rc;
		integer            ch;
		logic [63:0]       tok;
		logic [31:0]       adr;
		logic [31:0]       dat;
		logic [31:0]       expect_val;
		fd = $fopen("verif/sys_stimulus.txt", "r");
		assert (fd != 0) else begin
			$display("Stimulus file verif/sys_stimulus.txt could not be opened");
			errors++;
		end
		if (fd != 0) begin
			rc = $fscanf(fd, "%s", tok);
			while (rc == 1) begin
				if (tok == 64'("#")) begin
					ch = $fgetc(fd);
					while (ch != 10 && ch != -1) begin // Up to the newline.
						ch = $fgetc(fd);
					end
				end else begin
					rc = $fscanf(fd, "%h %h %h", adr, dat, expect_val);
					assert (rc == 3) else begin
						$display("Stimulus entry %0d has missing columns", op_q.size());
						errors++;
					end
					op_q.push_back(op_code(tok));
					adr_q.push_back(adr);
					dat_q.push_back(dat);
					exp_q.push_back(expect_val);
				end
				rc = $fscanf(fd, "%s", tok);
			end
			$fclose(fd);
		end
	endtask

	// ############################################################
	// Bus master and checks
	// ############################################################
	task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
			input logic [DATA_W-1:0] actual);
		assert (actual === expected) else begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic bus_access(input string name, input logic we, input logic [ADDR_W-1:0] adr,
			input logic [DATA_W-1:0] dat, input logic expect_err,
			output logic [DATA_W-1:0] rdata);
		int   lat;
		logic ack_seen;
		logic err_seen;
		lat = 0;
		ack_seen = 1'b0;
		err_seen = 1'b0;
		rdata = '0;
		@(posedge clk);
		bus_cyc <= 1'b1;
		bus_stb <= 1'b1;
		bus_we <= we;
		bus_adr <= adr;
		bus_dat <= dat;
		while (!ack_seen && !err_seen && lat < BUS_TIMEOUT) begin
			@(negedge clk);
			ack_seen = bus_ack;
			err_seen = bus_err;
			rdata = bus_rdat;
			if (!ack_seen && !err_seen) begin
				lat++;
			end
		end
		@(posedge clk);
		bus_cyc <= 1'b0;
		bus_stb <= 1'b0;
		bus_we <= 1'b0;
		assert (ack_seen || err_seen) else begin
			$display("Bus timeout: %s saw no acknowledge or error in %0d cycles", name, lat);
			errors++;
		end
		if (ack_seen || err_seen) begin
			check_value({name, " err"}, DATA_W'(expect_err), DATA_W'(err_seen));
			check_value({name, " ack"}, DATA_W'(!expect_err), DATA_W'(ack_seen));
			check_value({name, " latency"}, expect_err ? 0 : 1, DATA_W'(lat));
		end
	endtask

	task automatic run_op(input int idx);
		string             name;
		logic [DATA_W-1:0] rdata;
		logic [DATA_W-1:0] pattern;
		logic [DATA_W-1:0] expect_gpio;
		int                cyc;
		logic              bite_seen;
		name = $sformatf("op%0d %s %h", idx, op_name(op_q[idx]), adr_q[idx]);
		assert (op_q[idx] != OP_BAD) else begin
			$display("Stimulus entry %0d holds an unknown operation", idx);
			errors++;
		end
		case (op_q[idx])
			OP_W: bus_access(name, 1'b1, adr_q[idx], dat_q[idx], 1'b0, rdata);
			OP_R: begin
				bus_access(name, 1'b0, adr_q[idx], '0, 1'b0, rdata);
				check_value(name, exp_q[idx], rdata);
			end
			OP_E: bus_access(name, 1'b0, adr_q[idx], '0, 1'b1, rdata);
			OP_WAIT: repeat (dat_q[idx]) @(posedge clk);
			OP_G: begin
				pattern = $random(seed);
				expect_gpio = DATA_W'(pattern[GPIO_W-1:0]); // Only GPIO_W bits stored.
				bus_access(name, 1'b1, adr_q[idx], pattern, 1'b0, rdata);
				bus_access(name, 1'b0, adr_q[idx], '0, 1'b0, rdata);
				check_value(name, expect_gpio, rdata);
				check_value({name, " pins"}, expect_gpio, DATA_W'(gpio));
			end
			OP_B: begin
				@(posedge clk);
				irq_block <= dat_q[idx][0];
			end
			OP_V: begin
				@(negedge clk);
				check_value(name, exp_q[idx], irq_n);
			end
			OP_K: begin
				for (cyc = 0; cyc < dat_q[idx]; cyc += KICK_PERIOD) begin
					bus_access(name, 1'b1, KICK_ADR, '0, 1'b0, rdata);
					repeat (KICK_PERIOD - 2) begin
						@(negedge clk);
						check_value({name, " watchdog"}, '0, DATA_W'(watchdog));
					end
				end
			end
			OP_D: begin
				bite_seen = 1'b0;
				cyc = 0;
				while (!bite_seen && cyc < dat_q[idx]) begin
					@(negedge clk);
					bite_seen = watchdog;
					cyc++;
				end
				assert (bite_seen) else begin
					$display("Watchdog output never pulsed within %0d cycles at %s", cyc, name);
					errors++;
				end
			end
			default: ;
		endcase
	endtask

	// ############################################################
	// Run control
	// ############################################################
	initial begin
		read_stimulus();
		loaded = 1'b1;
		wait (reset_n);
		repeat (8) @(posedge clk); // Past the reset stretch.
		for (int i = 0; i < op_q.size(); i++) begin
			run_op(i);
		end
		repeat (2) @(posedge clk);
		$display("Summary: %0d errors in %0d operations", errors, op_q.size());
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		wait (loaded);
		repeat (op_q.size() * 50 + 2000) @(posedge clk);
		$display("Run did not finish within %0d cycles", op_q.size() * 50 + 2000);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 40,
	parameter int RESET_CYCLES = 10
) (
	output logic clk_o,
	output logic reset_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	initial begin
		reset_n_o <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		reset_n_o <= 1'b1; // Released on a rising edge.
	end

endmodule

`default_nettype wire
